// ==== com_link_defines.svh ====
`ifndef COM_LINK_DEFINES_SVH
`define COM_LINK_DEFINES_SVH

// framing bytes on the byte lane
`define COM_SYNC_BYTE 8'hA5

// lane value between frames
`define COM_IDLE_BYTE 8'h00

// long packets carry the 32-bit command, msb first
`define COM_PAYLOAD_BYTES 4

// short frame is sync + type + check
`define COM_SHORT_FRAME_BYTES 3

// long frame adds the payload bytes
`define COM_LONG_FRAME_BYTES (`COM_SHORT_FRAME_BYTES + `COM_PAYLOAD_BYTES)

`endif

// ==== com_link_pkg.sv ====
`default_nettype none

package com_link_pkg;

    // packet type codes, 4 and 8..15 are not used on the link
    typedef enum logic [3:0] {
        BAG_INIT   = 4'd0,   // no packet
        BAG_ACK    = 4'd1,
        BAG_NAK    = 4'd2,
        BAG_STL    = 4'd3,
        BAG_DIDX   = 4'd5,
        BAG_DPARAM = 4'd6,
        BAG_DDIDX  = 4'd7
    } bag_type_e;

    typedef logic [31:0] cmd_word_t;

    // long packets carry the command word, sender and receiver both size
    // their frames from this
    function automatic logic has_payload(bag_type_e t);
        return (t == BAG_DIDX) || (t == BAG_DPARAM) || (t == BAG_DDIDX);
    endfunction

endpackage

`default_nettype wire

// ==== com_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module com_link_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // sender side
    input  wire logic                  tx_fs,
    output logic                       tx_fd,
    input  wire com_link_pkg::bag_type_e tx_btype,
    input  wire com_link_pkg::cmd_word_t tx_data_cmd,
    // byte lane, closed outside so it can be tapped or damaged
    output logic [7:0]                 usb_txd,
    input  wire logic [7:0]            com_rxd,
    // receiver side
    output logic                       rx_fs,
    input  wire logic                  rx_fd,
    output com_link_pkg::bag_type_e    rx_btype,
    output com_link_pkg::cmd_word_t    rx_data_cmd,
    output logic                       rx_err,
    output logic                       rx_overrun
);

    usb_tx u_usb_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_fs       (tx_fs),
        .tx_fd       (tx_fd),
        .tx_btype    (tx_btype),
        .tx_data_cmd (tx_data_cmd),
        .usb_txd     (usb_txd)
    );

    com_rx u_com_rx (
        .clk         (clk),
        .rst         (rst),
        .com_rxd     (com_rxd),
        .rx_fs       (rx_fs),
        .rx_fd       (rx_fd),
        .rx_btype    (rx_btype),
        .rx_data_cmd (rx_data_cmd),
        .rx_err      (rx_err),
        .rx_overrun  (rx_overrun)
    );

endmodule

`default_nettype wire

// ==== com_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "com_link_defines.svh"

module com_rx (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [7:0]            com_rxd,
    output logic                       rx_fs,
    input  wire logic                  rx_fd,
    output com_link_pkg::bag_type_e    rx_btype,
    output com_link_pkg::cmd_word_t    rx_data_cmd,
    output logic                       rx_err,
    output logic                       rx_overrun
);

    import com_link_pkg::*;

    localparam int CNT_W = $clog2(`COM_PAYLOAD_BYTES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`COM_PAYLOAD_BYTES - 1);

    typedef enum logic [1:0] {
        ST_HUNT,
        ST_TYPE,
        ST_PAYLOAD,
        ST_CHECK
    } rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [7:0]       rxd_q;

    bag_type_e        type_q;
    logic             type_bad;
    cmd_word_t        shift_q;
    logic [7:0]       csum;

    logic             frm_good;
    logic             frm_bad;
    logic             sum_ok;
    bag_type_e        lane_type;

    // only codes that name a real packet may appear in a frame
    function automatic logic type_known(logic [3:0] code);
        case (code)
            BAG_ACK, BAG_NAK, BAG_STL: return 1'b1;
            BAG_DIDX, BAG_DPARAM, BAG_DDIDX: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign lane_type = bag_type_e'(rxd_q[3:0]);
    assign sum_ok    = !type_bad && (rxd_q == csum);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_q    <= `COM_IDLE_BYTE;
            state    <= ST_HUNT;
            cnt      <= '0;
            frm_good <= 1'b0;
            frm_bad  <= 1'b0;
        end else begin
            rxd_q    <= com_rxd;   // one register stage ahead of the decoder
            frm_good <= 1'b0;
            frm_bad  <= 1'b0;
            case (state)
                ST_HUNT: begin
                    if (rxd_q == `COM_SYNC_BYTE) state <= ST_TYPE;
                end
                ST_TYPE: begin
                    // length follows the low nibble even when the check fails,
                    // so a damaged type still ends at the checksum byte
                    cnt   <= '0;
                    state <= has_payload(lane_type) ? ST_PAYLOAD : ST_CHECK;
                end
                ST_PAYLOAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_LAST) state <= ST_CHECK;
                end
                ST_CHECK: begin
                    frm_good <= sum_ok;
                    frm_bad  <= !sum_ok;
                    state    <= ST_HUNT;
                end
                default: state <= ST_HUNT;
            endcase
        end
    end

    // frame contents, rebuilt as the bytes arrive
    always_ff @(posedge clk) begin
        case (state)
            ST_TYPE: begin
                type_q   <= lane_type;
                type_bad <= (rxd_q[7:4] != ~rxd_q[3:0]) || !type_known(rxd_q[3:0]);
                csum     <= rxd_q;
            end
            ST_PAYLOAD: begin
                shift_q <= {shift_q[23:0], rxd_q};   // msb first on the lane
                csum    <= csum ^ rxd_q;
            end
            default: ;
        endcase
    end

    // output stage, the held packet only moves when nothing is pending
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_fs      <= 1'b0;
            rx_btype   <= BAG_INIT;
            rx_err     <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_err     <= frm_bad;
            rx_overrun <= frm_good && rx_fs;   // new frame dropped
            if (rx_fs && rx_fd) begin
                rx_fs <= 1'b0;
            end else if (frm_good && !rx_fs) begin
                rx_fs    <= 1'b1;
                rx_btype <= type_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frm_good && !rx_fs) begin
            rx_data_cmd <= has_payload(type_q) ? shift_q : '0;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and judge the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_com_link -o tb_com_link \
    && ./obj_dir/tb_com_link > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "run reported failure"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0

// ==== sources.f ====
+incdir+.
com_link_pkg.sv
usb_tx.sv
com_rx.sv
com_link_top.sv
tb_com_link.sv

// ==== tb_com_link.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "com_link_defines.svh"

module tb_com_link;

    import com_link_pkg::*;

    localparam int NUM_FRAMES   = 15;
    localparam int FRAME_CYCLES = `COM_LONG_FRAME_BYTES + 12;   // frame plus release and ack
    localparam int WD_CYCLES    = (16 + NUM_FRAMES * FRAME_CYCLES) * 4;
    localparam int RESP_LIMIT   = 20;

    logic       clk;
    logic       rst;
    logic       tx_fs;
    logic       tx_fd;
    bag_type_e  tx_btype;
    cmd_word_t  tx_data_cmd;
    logic [7:0] usb_txd;
    logic [7:0] com_rxd;
    logic       rx_fs;
    logic       rx_fd;
    bag_type_e  rx_btype;
    cmd_word_t  rx_data_cmd;
    logic       rx_err;
    logic       rx_overrun;

    logic       corrupt_en;
    logic [7:0] corrupt_mask;
    int         corrupt_pos;
    int         lane_pos;        // byte number of the frame now on the lane

    int         seed;
    int         err_cnt;
    int         tests_pass;
    int         tests_fail;
    int         fs_lat;
    int         err_hits;
    int         ovr_hits;

    logic [7:0] exp_lane[$];
    logic [7:0] got_lane[$];
    bag_type_e  exp_type_q[$];
    cmd_word_t  exp_cmd_q[$];

    // loopback, one chosen byte can be damaged on the way
    assign com_rxd = usb_txd ^ ((corrupt_en && lane_pos == corrupt_pos) ? corrupt_mask : 8'h00);

    com_link_top u_com_link_top (
        .clk         (clk),
        .rst         (rst),
        .tx_fs       (tx_fs),
        .tx_fd       (tx_fd),
        .tx_btype    (tx_btype),
        .tx_data_cmd (tx_data_cmd),
        .usb_txd     (usb_txd),
        .com_rxd     (com_rxd),
        .rx_fs       (rx_fs),
        .rx_fd       (rx_fd),
        .rx_btype    (rx_btype),
        .rx_data_cmd (rx_data_cmd),
        .rx_err      (rx_err),
        .rx_overrun  (rx_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired, the tests did not finish in %0d cycles", WD_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // handshake rules
    a_fs_hold: assert property (@(posedge clk) disable iff (rst) (rx_fs && !rx_fd) |=> rx_fs)
        else begin
            $display("ERR %0t rx_fs expected 1 got 0", $time);
            err_cnt++;
        end
    a_fd_hold: assert property (@(posedge clk) disable iff (rst) (tx_fd && tx_fs) |=> tx_fd)
        else begin
            $display("ERR %0t tx_fd expected 1 got 0", $time);
            err_cnt++;
        end
    a_fd_fall: assert property (@(posedge clk) disable iff (rst) (tx_fd && !tx_fs) |=> !tx_fd)
        else begin
            $display("ERR %0t tx_fd expected 0 got 1", $time);
            err_cnt++;
        end
    a_err_pulse: assert property (@(posedge clk) disable iff (rst) rx_err |=> !rx_err)
        else begin
            $display("ERR %0t rx_err expected 0 got 1", $time);
            err_cnt++;
        end
    a_ovr_pulse: assert property (@(posedge clk) disable iff (rst) rx_overrun |=> !rx_overrun)
        else begin
            $display("ERR %0t rx_overrun expected 0 got 1", $time);
            err_cnt++;
        end

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            tests_pass++;
            $display("test %s passed", name);
        end else begin
            tests_fail++;
            $display("test %s failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // sync, type with inverse nibble, payload msb first, xor over all but sync
    task automatic build_expected(input bag_type_e t, input cmd_word_t c);
        logic [7:0] sum;
        logic [7:0] b;
        int         i;
        exp_lane.delete();
        exp_lane.push_back(`COM_SYNC_BYTE);
        sum = {~t, t};
        exp_lane.push_back(sum);
        if (has_payload(t)) begin
            for (i = 0; i < `COM_PAYLOAD_BYTES; i++) begin
                b = c[31 - 8 * i -: 8];
                exp_lane.push_back(b);
                sum = sum ^ b;
            end
        end
        exp_lane.push_back(sum);
    endtask

    task automatic send_frame(input bag_type_e t, input cmd_word_t c, input int bad_pos,
                              input logic [7:0] bad_mask);
        int   k;
        int   i;
        logic prev_fs;
        fs_lat   = 0;
        err_hits = 0;
        ovr_hits = 0;
        prev_fs  = rx_fs;
        got_lane.delete();
        build_expected(t, c);
        @(posedge clk);
        tx_btype     <= t;
        tx_data_cmd  <= c;
        tx_fs        <= 1'b1;
        corrupt_en   <= (bad_pos != 0);
        corrupt_pos  <= bad_pos;
        corrupt_mask <= bad_mask;
        @(posedge clk);   // sender samples tx_fs here
        k = 0;
        while (!(tx_fd && (fs_lat != 0 || err_hits != 0 || ovr_hits != 0)) && k < RESP_LIMIT) begin
            @(posedge clk);
            k++;
            lane_pos <= k;
            @(negedge clk);
            if (k <= exp_lane.size()) got_lane.push_back(usb_txd);
            if (rx_fs && !prev_fs && fs_lat == 0) fs_lat = k;
            if (rx_err) err_hits++;
            if (rx_overrun) ovr_hits++;
            prev_fs = rx_fs;
        end
        if (k >= RESP_LIMIT) begin
            $display("frame of type %s got no response within %0d cycles", t.name(), k);
            err_cnt++;
        end
        if (got_lane.size() != exp_lane.size()) begin
            $display("lane showed %0d bytes of a %0d byte frame", got_lane.size(), exp_lane.size());
            err_cnt++;
        end else begin
            for (i = 0; i < exp_lane.size(); i++)
                expect_eq($sformatf("usb_txd[%0d]", i), 32'(exp_lane[i]), 32'(got_lane[i]));
        end
        @(posedge clk);
        lane_pos   <= 0;
        corrupt_en <= 1'b0;
        tx_fs      <= 1'b0;
        k = 0;
        do begin
            @(negedge clk);
            k++;
        end while (tx_fd && k < 8);
        if (tx_fd) begin
            $display("tx_fd stayed high after tx_fs fell");
            err_cnt++;
        end
    endtask

    task automatic take_packet();
        bag_type_e t;
        cmd_word_t c;
        int        k;
        if (exp_type_q.size() == 0) begin
            $display("a packet was presented with none expected");
            err_cnt++;
        end else begin
            t = exp_type_q.pop_front();
            c = exp_cmd_q.pop_front();
            expect_eq("rx_btype", 32'(t), 32'(rx_btype));
            if (has_payload(t)) expect_eq("rx_data_cmd", c, rx_data_cmd);
        end
        repeat (2) @(posedge clk);   // rx_fs has to wait for us
        rx_fd <= 1'b1;
        k = 0;
        do begin
            @(negedge clk);
            k++;
        end while (rx_fs && k < 8);
        if (rx_fs) begin
            $display("rx_fs did not fall after rx_fd was raised");
            err_cnt++;
        end
        @(posedge clk);
        rx_fd <= 1'b0;
    endtask

    task automatic good_frame(input bag_type_e t, input cmd_word_t c);
        int len;
        len = has_payload(t) ? `COM_LONG_FRAME_BYTES : `COM_SHORT_FRAME_BYTES;
        exp_type_q.push_back(t);
        exp_cmd_q.push_back(c);
        send_frame(t, c, 0, 8'h00);
        expect_eq("rx_fs cycles", 32'(1 + len + 2), fs_lat);
        expect_eq("rx_err pulses", 0, err_hits);
        take_packet();
    endtask

    task automatic bad_frame(input bag_type_e t, input cmd_word_t c, input int pos,
                             input logic [7:0] mask);
        send_frame(t, c, pos, mask);
        expect_eq("rx_err pulses", 1, err_hits);
        expect_eq("rx_fs rises", 0, fs_lat);
        expect_eq("rx_fs", 0, 32'(rx_fs));
    endtask

    initial begin
        int        err_before;
        int        i;
        cmd_word_t first_cmd;
        seed         = 79;
        err_cnt      = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        rst          = 1'b1;
        tx_fs        = 1'b0;
        tx_btype     = BAG_INIT;
        tx_data_cmd  = '0;
        rx_fd        = 1'b0;
        corrupt_en   = 1'b0;
        corrupt_mask = 8'h00;
        corrupt_pos  = 0;
        lane_pos     = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        err_before = err_cnt;
        expect_eq("tx_fd", 0, 32'(tx_fd));
        expect_eq("rx_fs", 0, 32'(rx_fs));
        expect_eq("rx_err", 0, 32'(rx_err));
        expect_eq("rx_overrun", 0, 32'(rx_overrun));
        expect_eq("usb_txd", 32'(`COM_IDLE_BYTE), 32'(usb_txd));
        expect_eq("rx_btype", 32'(BAG_INIT), 32'(rx_btype));
        finish_test("reset values", err_before);

        err_before = err_cnt;
        good_frame(BAG_ACK, '0);
        good_frame(BAG_NAK, '0);
        good_frame(BAG_STL, '0);
        finish_test("short frames", err_before);

        err_before = err_cnt;
        for (i = 0; i < 2; i++) begin
            good_frame(BAG_DIDX, $random(seed));
            good_frame(BAG_DPARAM, $random(seed));
            good_frame(BAG_DDIDX, $random(seed));
        end
        finish_test("long frames", err_before);

        err_before = err_cnt;
        bad_frame(BAG_ACK, '0, `COM_SHORT_FRAME_BYTES, 8'h01);   // checksum byte
        bad_frame(BAG_DIDX, $random(seed), 4, 8'h10);            // second payload byte
        bad_frame(BAG_STL, '0, 2, 8'h80);                        // inverse nibble
        bad_frame(bag_type_e'(4'd4), '0, 0, 8'h00);              // code 4 names no packet
        finish_test("corrupted frames", err_before);

        err_before = err_cnt;
        first_cmd  = $random(seed);
        exp_type_q.push_back(BAG_DPARAM);
        exp_cmd_q.push_back(first_cmd);
        send_frame(BAG_DPARAM, first_cmd, 0, 8'h00);
        expect_eq("rx_fs", 1, 32'(rx_fs));
        send_frame(BAG_NAK, '0, 0, 8'h00);   // arrives while the first is still held
        expect_eq("rx_overrun pulses", 1, ovr_hits);
        expect_eq("rx_err pulses", 0, err_hits);
        take_packet();
        finish_test("overrun", err_before);

        $display("tests passed %0d failed %0d, check errors %0d", tests_pass, tests_fail, err_cnt);
        if (tests_fail == 0 && err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== usb_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "com_link_defines.svh"

module usb_tx (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  tx_fs,
    output logic                       tx_fd,
    input  wire com_link_pkg::bag_type_e tx_btype,
    input  wire com_link_pkg::cmd_word_t tx_data_cmd,
    output logic [7:0]                 usb_txd
);

    import com_link_pkg::*;

    localparam int CNT_W = $clog2(`COM_PAYLOAD_BYTES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`COM_PAYLOAD_BYTES - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SYNC,
        ST_TYPE,
        ST_PAYLOAD,
        ST_CHECK,
        ST_DONE
    } tx_state_e;

    tx_state_e        state;
    logic [CNT_W-1:0] cnt;

    bag_type_e        btype_q;
    cmd_word_t        cmd_q;
    logic [7:0]       csum;

    logic [7:0]       type_byte;
    logic [7:0]       pay_byte;
    logic             start;

    assign type_byte = {~btype_q, btype_q};   // inverse nibble guards the type
    assign pay_byte  = cmd_q[31:24];
    assign start     = (state == ST_IDLE) && tx_fs && !tx_fd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            tx_fd   <= 1'b0;
            usb_txd <= `COM_IDLE_BYTE;
        end else begin
            case (state)
                ST_IDLE: begin
                    usb_txd <= `COM_IDLE_BYTE;
                    if (start) state <= ST_SYNC;
                end
                ST_SYNC: begin
                    usb_txd <= `COM_SYNC_BYTE;
                    state   <= ST_TYPE;
                end
                ST_TYPE: begin
                    usb_txd <= type_byte;
                    cnt     <= '0;
                    state   <= has_payload(btype_q) ? ST_PAYLOAD : ST_CHECK;
                end
                ST_PAYLOAD: begin
                    usb_txd <= pay_byte;
                    cnt     <= cnt + 1'b1;
                    if (cnt == CNT_LAST) state <= ST_CHECK;
                end
                ST_CHECK: begin
                    usb_txd <= csum;
                    state   <= ST_DONE;
                end
                ST_DONE: begin
                    // hold done until the user lets go of tx_fs
                    usb_txd <= `COM_IDLE_BYTE;
                    tx_fd   <= tx_fs;
                    if (!tx_fs) state <= ST_IDLE;
                end
                default: begin
                    usb_txd <= `COM_IDLE_BYTE;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

    // frame contents, captured at start and consumed byte by byte
    always_ff @(posedge clk) begin
        if (start) begin
            btype_q <= tx_btype;
            cmd_q   <= tx_data_cmd;
        end else if (state == ST_PAYLOAD) begin
            cmd_q <= {cmd_q[23:0], 8'h00};   // next byte to the top
        end

        if (state == ST_TYPE) begin
            csum <= type_byte;
        end else if (state == ST_PAYLOAD) begin
            csum <= csum ^ pay_byte;
        end
    end

endmodule

`default_nettype wire
